/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = dispatch_stage_tb
FILELIST  = dispatch_stage.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* dispatch_stage.f */
logic/dispatch_pkg.sv
logic/credit_tracker.sv
logic/sq_alloc.sv
logic/inst_decode.sv
logic/dispatch_select.sv
logic/dispatch_stage.sv
verif/dispatch_stage_assert.sv
verif/dispatch_stage_tb.sv

/* logic/credit_tracker.sv */
`timescale 1ns/1ps

module credit_tracker #(
    parameter int DEPTH = 8
) (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic [dispatch_pkg::CNT_W-1:0] used,
    input  logic [dispatch_pkg::CNT_W-1:0] returned,
    output logic [dispatch_pkg::CNT_W-1:0] open
);
    import dispatch_pkg::*;

    localparam int CNT_BITS = $clog2(DEPTH + 1);

    // free entries left in the structure
    logic [CNT_BITS-1:0] count;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            count <= CNT_BITS'(DEPTH);
        end else begin
            count <= count - CNT_BITS'(used) + CNT_BITS'(returned);
        end
    end

    // at most N can be used in one cycle
    assign open = (int'(count) > N) ? CNT_W'(N) : CNT_W'(count);

endmodule

/* logic/dispatch_pkg.sv */
package dispatch_pkg;

    // dispatch width and back-end structure sizes
    localparam int N        = 4;
    localparam int CNT_W    = $clog2(N + 1);
    localparam int ROB_SZ   = 16;
    localparam int RS_SZ    = 8;
    localparam int SQ_SZ    = 8;
    localparam int BS_SZ    = 4;
    localparam int SQ_IDX_W = $clog2(SQ_SZ);

    // rv32i major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // register layout, also the source of the I, U and J immediates
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    // store immediate is split around the register fields
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_view_t;

    // branch offset bits, scrambled as in the ISA
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_view_t;

    typedef union packed {
        r_view_t r_view;
        s_view_t s_view;
        b_view_t b_view;
    } rv_inst_u;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        rv_inst_u    inst;
    } inst_packet_t;

    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JUMP,
        CLS_ILLEGAL
    } op_class_e;

    typedef struct packed {
        logic                valid;
        logic [31:0]         pc;
        op_class_e           op_class;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [31:0]         imm;
        logic [2:0]          funct3;
        logic                uses_rs1;
        logic                uses_rs2;
        logic                writes_rd;
        logic                cond_branch;
        logic                uncond_branch;
        logic                rd_mem;
        logic                wr_mem;
        logic                illegal;
        logic [SQ_IDX_W-1:0] sq_tail;
    } decoded_packet_t;

    // per-cycle counts handed back by the back-end
    typedef struct packed {
        logic [CNT_W-1:0] rob;
        logic [CNT_W-1:0] rs;
        logic [CNT_W-1:0] sq;
        logic [CNT_W-1:0] bs;
    } credit_ret_t;

endpackage

/* logic/dispatch_select.sv */
`timescale 1ns/1ps

module dispatch_select (
    input  logic                                                 clock,
    input  logic                                                 rst_n,
    input  dispatch_pkg::decoded_packet_t [dispatch_pkg::N-1:0]  decoded,
    input  logic [dispatch_pkg::CNT_W-1:0]                       rob_open,
    input  logic [dispatch_pkg::CNT_W-1:0]                       rs_open,
    input  logic [dispatch_pkg::CNT_W-1:0]                       sq_open,
    input  logic [dispatch_pkg::CNT_W-1:0]                       bs_open,
    input  logic [dispatch_pkg::SQ_IDX_W-1:0]                    sq_tail,
    output logic [dispatch_pkg::CNT_W-1:0]                       take_count,
    output logic [dispatch_pkg::CNT_W-1:0]                       stores_used,
    output logic [dispatch_pkg::CNT_W-1:0]                       branches_used,
    output dispatch_pkg::decoded_packet_t [dispatch_pkg::N-1:0]  out_bundle,
    output logic [dispatch_pkg::CNT_W-1:0]                       out_count
);
    import dispatch_pkg::*;

    logic [CNT_W-1:0]                 slot_limit;
    decoded_packet_t [N-1:0]          sel_bundle;

    // store queue slot that lies a given number of stores past the tail
    function automatic logic [SQ_IDX_W-1:0] tag_at(input logic [SQ_IDX_W-1:0] tail,
                                                   input logic [CNT_W-1:0]    ahead);
        logic [SQ_IDX_W:0] sum;
        sum = {1'b0, tail} + (SQ_IDX_W + 1)'(ahead);
        if (int'(sum) >= SQ_SZ) begin
            sum = sum - (SQ_IDX_W + 1)'(SQ_SZ);
        end
        return sum[SQ_IDX_W-1:0];
    endfunction

    // rob and rs both take one entry per packet
    assign slot_limit = (rob_open < rs_open) ? rob_open : rs_open;

    always_comb begin
        logic            stop;
        logic            is_br;
        decoded_packet_t pkt;
        stop          = 1'b0;
        take_count    = '0;
        stores_used   = '0;
        branches_used = '0;
        sel_bundle    = '0;
        for (int i = 0; i < N; i++) begin
            pkt   = decoded[i];
            is_br = pkt.cond_branch || pkt.uncond_branch;
            if (!stop) begin
                if (!pkt.valid || CNT_W'(i) >= slot_limit) begin
                    stop = 1'b1;
                end else if (is_br && (i != 0 || bs_open == '0)) begin
                    // later branches wait for the next cycle in slot 0
                    stop = 1'b1;
                end else if (pkt.wr_mem && stores_used >= sq_open) begin
                    stop = 1'b1;
                end else begin
                    sel_bundle[i] = pkt;
                    if (pkt.wr_mem || pkt.rd_mem) begin
                        sel_bundle[i].sq_tail = tag_at(sq_tail, stores_used);
                    end else begin
                        sel_bundle[i].sq_tail = '0;
                    end
                    if (pkt.wr_mem) begin
                        stores_used = stores_used + 1'b1;
                    end
                    if (is_br) begin
                        branches_used = branches_used + 1'b1;
                    end
                    take_count = take_count + 1'b1;
                end
            end
        end
    end

    // payload follows the selection, only the valids and count are reset
    always_ff @(posedge clock) begin
        out_bundle <= sel_bundle;
        if (!rst_n) begin
            out_count <= '0;
            for (int i = 0; i < N; i++) begin
                out_bundle[i].valid <= 1'b0;
            end
        end else begin
            out_count <= take_count;
        end
    end

endmodule

/* logic/dispatch_stage.sv */
`timescale 1ns/1ps

module dispatch_stage (
    input  logic                                                 clock,
    input  logic                                                 rst_n,
    input  dispatch_pkg::inst_packet_t    [dispatch_pkg::N-1:0]  insts,
    input  dispatch_pkg::credit_ret_t                            credit_ret,
    output logic [dispatch_pkg::CNT_W-1:0]                       take_count,
    output dispatch_pkg::decoded_packet_t [dispatch_pkg::N-1:0]  out_bundle,
    output logic [dispatch_pkg::CNT_W-1:0]                       out_count
);
    import dispatch_pkg::*;

    decoded_packet_t [N-1:0] decoded;
    logic [CNT_W-1:0]        rob_open;
    logic [CNT_W-1:0]        rs_open;
    logic [CNT_W-1:0]        sq_open;
    logic [CNT_W-1:0]        bs_open;
    logic [CNT_W-1:0]        stores_used;
    logic [CNT_W-1:0]        branches_used;
    logic [SQ_IDX_W-1:0]     sq_tail;

    inst_decode inst_decode_inst (
        .insts  (insts),
        .decoded(decoded)
    );

    dispatch_select dispatch_select_inst (
        .clock        (clock),
        .rst_n        (rst_n),
        .decoded      (decoded),
        .rob_open     (rob_open),
        .rs_open      (rs_open),
        .sq_open      (sq_open),
        .bs_open      (bs_open),
        .sq_tail      (sq_tail),
        .take_count   (take_count),
        .stores_used  (stores_used),
        .branches_used(branches_used),
        .out_bundle   (out_bundle),
        .out_count    (out_count)
    );

    // every dispatched packet takes a rob and an rs entry
    credit_tracker #(.DEPTH(ROB_SZ)) rob_credits (
        .clock(clock), .rst_n(rst_n),
        .used(take_count), .returned(credit_ret.rob), .open(rob_open)
    );

    credit_tracker #(.DEPTH(RS_SZ)) rs_credits (
        .clock(clock), .rst_n(rst_n),
        .used(take_count), .returned(credit_ret.rs), .open(rs_open)
    );

    credit_tracker #(.DEPTH(BS_SZ)) bs_credits (
        .clock(clock), .rst_n(rst_n),
        .used(branches_used), .returned(credit_ret.bs), .open(bs_open)
    );

    sq_alloc sq_alloc_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .stores_used(stores_used),
        .returned   (credit_ret.sq),
        .open       (sq_open),
        .sq_tail    (sq_tail)
    );

endmodule

/* logic/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode (
    input  dispatch_pkg::inst_packet_t    [dispatch_pkg::N-1:0] insts,
    output dispatch_pkg::decoded_packet_t [dispatch_pkg::N-1:0] decoded
);
    import dispatch_pkg::*;

    function automatic logic [31:0] imm_i(input rv_inst_u w);
        return {{20{w.r_view.funct7[6]}}, w.r_view.funct7, w.r_view.rs2};
    endfunction

    function automatic logic [31:0] imm_s(input rv_inst_u w);
        return {{20{w.s_view.imm_hi[6]}}, w.s_view.imm_hi, w.s_view.imm_lo};
    endfunction

    function automatic logic [31:0] imm_b(input rv_inst_u w);
        return {{19{w.b_view.imm12}}, w.b_view.imm12, w.b_view.imm11,
                w.b_view.imm10_5, w.b_view.imm4_1, 1'b0};
    endfunction

    function automatic logic [31:0] imm_u(input rv_inst_u w);
        return {w.r_view.funct7, w.r_view.rs2, w.r_view.rs1, w.r_view.funct3, 12'b0};
    endfunction

    // J offset bits live in funct7, rs2, rs1 and funct3 of the register layout
    function automatic logic [31:0] imm_j(input rv_inst_u w);
        return {{11{w.r_view.funct7[6]}}, w.r_view.funct7[6], w.r_view.rs1,
                w.r_view.funct3, w.r_view.rs2[0], w.r_view.funct7[5:0],
                w.r_view.rs2[4:1], 1'b0};
    endfunction

    function automatic decoded_packet_t decode_one(input inst_packet_t pkt);
        decoded_packet_t d;
        logic [2:0]      f3;
        d        = '0;
        f3       = pkt.inst.r_view.funct3;
        d.valid  = pkt.valid;
        d.pc     = pkt.pc;
        d.rd     = pkt.inst.r_view.rd;
        d.rs1    = pkt.inst.r_view.rs1;
        d.rs2    = pkt.inst.r_view.rs2;
        d.funct3 = f3;
        d.op_class = CLS_ALU;
        case (pkt.inst.r_view.opcode)
            OPC_LUI, OPC_AUIPC: begin
                d.writes_rd = 1'b1;
                d.imm       = imm_u(pkt.inst);
            end
            OPC_JAL: begin
                d.op_class      = CLS_JUMP;
                d.writes_rd     = 1'b1;
                d.uncond_branch = 1'b1;
                d.imm           = imm_j(pkt.inst);
            end
            OPC_JALR: begin
                d.op_class      = CLS_JUMP;
                d.uses_rs1      = 1'b1;
                d.writes_rd     = 1'b1;
                d.uncond_branch = 1'b1;
                d.imm           = imm_i(pkt.inst);
            end
            OPC_BRANCH: begin
                d.op_class    = CLS_BRANCH;
                d.uses_rs1    = 1'b1;
                d.uses_rs2    = 1'b1;
                d.cond_branch = 1'b1;
                d.imm         = imm_b(pkt.inst);
                // beq bne blt bge bltu bgeu only
                d.illegal     = (f3 == 3'b010) || (f3 == 3'b011);
            end
            OPC_LOAD: begin
                d.op_class  = CLS_LOAD;
                d.uses_rs1  = 1'b1;
                d.writes_rd = 1'b1;
                d.rd_mem    = 1'b1;
                d.imm       = imm_i(pkt.inst);
                d.illegal   = !(f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
            end
            OPC_STORE: begin
                d.op_class = CLS_STORE;
                d.uses_rs1 = 1'b1;
                d.uses_rs2 = 1'b1;
                d.wr_mem   = 1'b1;
                d.imm      = imm_s(pkt.inst);
                d.illegal  = (f3 > 3'b010);
            end
            OPC_OP_IMM: begin
                d.uses_rs1  = 1'b1;
                d.writes_rd = 1'b1;
                d.imm       = imm_i(pkt.inst);
            end
            OPC_OP: begin
                d.uses_rs1  = 1'b1;
                d.uses_rs2  = 1'b1;
                d.writes_rd = 1'b1;
            end
            default: d.illegal = 1'b1;
        endcase
        // illegal words carry no operands and claim no sq or branch credit
        if (d.illegal) begin
            d.op_class      = CLS_ILLEGAL;
            d.imm           = '0;
            d.uses_rs1      = 1'b0;
            d.uses_rs2      = 1'b0;
            d.writes_rd     = 1'b0;
            d.cond_branch   = 1'b0;
            d.uncond_branch = 1'b0;
            d.rd_mem        = 1'b0;
            d.wr_mem        = 1'b0;
        end
        return d;
    endfunction

    always_comb begin
        for (int i = 0; i < N; i++) begin
            decoded[i] = decode_one(insts[i]);
        end
    end

endmodule

/* logic/sq_alloc.sv */
`timescale 1ns/1ps

module sq_alloc (
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic [dispatch_pkg::CNT_W-1:0]    stores_used,
    input  logic [dispatch_pkg::CNT_W-1:0]    returned,
    output logic [dispatch_pkg::CNT_W-1:0]    open,
    output logic [dispatch_pkg::SQ_IDX_W-1:0] sq_tail
);
    import dispatch_pkg::*;

    logic [SQ_IDX_W:0] tail_sum;

    credit_tracker #(
        .DEPTH(SQ_SZ)
    ) sq_credits (
        .clock   (clock),
        .rst_n   (rst_n),
        .used    (stores_used),
        .returned(returned),
        .open    (open)
    );

    // circular tail, wraps at the queue size
    always_comb begin
        tail_sum = {1'b0, sq_tail} + (SQ_IDX_W + 1)'(stores_used);
        if (int'(tail_sum) >= SQ_SZ) begin
            tail_sum = tail_sum - (SQ_IDX_W + 1)'(SQ_SZ);
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sq_tail <= '0;
        end else begin
            sq_tail <= tail_sum[SQ_IDX_W-1:0];
        end
    end

endmodule

/* verif/dispatch_stage_assert.sv */
`timescale 1ns/1ps

module dispatch_stage_assert (
    input logic                                                 clock,
    input logic                                                 rst_n,
    input dispatch_pkg::decoded_packet_t [dispatch_pkg::N-1:0]  out_bundle,
    input logic [dispatch_pkg::CNT_W-1:0]                       out_count,
    input logic [$clog2(dispatch_pkg::ROB_SZ + 1)-1:0]          rob_count,
    input logic [$clog2(dispatch_pkg::RS_SZ + 1)-1:0]           rs_count,
    input logic [$clog2(dispatch_pkg::SQ_SZ + 1)-1:0]           sq_count,
    input logic [$clog2(dispatch_pkg::BS_SZ + 1)-1:0]           bs_count
);
    import dispatch_pkg::*;

    logic late_branch;
    logic valid_gap;

    always_comb begin
        late_branch = 1'b0;
        valid_gap   = 1'b0;
        for (int i = 1; i < N; i++) begin
            if (out_bundle[i].valid &&
                (out_bundle[i].cond_branch || out_bundle[i].uncond_branch)) begin
                late_branch = 1'b1;
            end
            // valids must be packed from slot 0
            if (out_bundle[i].valid && !out_bundle[i-1].valid) begin
                valid_gap = 1'b1;
            end
        end
    end

    rob_bound: assert property (@(posedge clock) disable iff (!rst_n) int'(rob_count) <= ROB_SZ)
        else $error("rob credit count above depth");
    rs_bound: assert property (@(posedge clock) disable iff (!rst_n) int'(rs_count) <= RS_SZ)
        else $error("rs credit count above depth");
    sq_bound: assert property (@(posedge clock) disable iff (!rst_n) int'(sq_count) <= SQ_SZ)
        else $error("sq credit count above depth");
    bs_bound: assert property (@(posedge clock) disable iff (!rst_n) int'(bs_count) <= BS_SZ)
        else $error("branch stack credit count above depth");
    count_bound: assert property (@(posedge clock) disable iff (!rst_n) int'(out_count) <= N)
        else $error("out_count above dispatch width");
    branch_slot: assert property (@(posedge clock) disable iff (!rst_n) !late_branch)
        else $error("branch or jump dispatched outside slot 0");
    valid_prefix: assert property (@(posedge clock) disable iff (!rst_n) !valid_gap)
        else $error("out_bundle valids are not a prefix");

endmodule

bind dispatch_stage dispatch_stage_assert dispatch_stage_assert_inst (
    .clock     (clock),
    .rst_n     (rst_n),
    .out_bundle(out_bundle),
    .out_count (out_count),
    .rob_count (rob_credits.count),
    .rs_count  (rs_credits.count),
    .sq_count  (sq_alloc_inst.sq_credits.count),
    .bs_count  (bs_credits.count)
);

/* verif/dispatch_stage_tb.sv */
`timescale 1ns/1ps

module dispatch_stage_tb;
    import dispatch_pkg::*;

    // marker for a random addi filler word
    localparam logic [31:0] FILL      = 32'hffff_ffff;
    localparam logic [31:0] BEQ       = 32'h0020_84e3;
    localparam logic [31:0] BNE_NEG   = 32'hfe41_9ee3;
    localparam logic [31:0] JAL       = 32'ha5d5_a0ef;
    localparam logic [31:0] JALR      = 32'h0002_80e7;
    localparam logic [31:0] SW_NEG    = 32'hfe53_2c23;
    localparam logic [31:0] LW        = 32'h00c3_2383;
    localparam logic [31:0] LW_BAD    = 32'h00c3_3383;
    localparam logic [31:0] LUI       = 32'h1234_5437;
    localparam logic [31:0] AUIPC     = 32'h0000_1497;
    localparam logic [31:0] ADD       = 32'h0020_81b3;
    localparam logic [31:0] ADDI      = 32'h0051_0093;
    localparam logic [31:0] ILL       = 32'h0000_0000;
    localparam int          EDGE_WAIT = 40;
    localparam int          IDLE_WAIT = 5;

    logic                    clock;
    logic                    rst_n;
    inst_packet_t [N-1:0]    insts;
    credit_ret_t             credit_ret;
    logic [CNT_W-1:0]        take_count;
    decoded_packet_t [N-1:0] out_bundle;
    logic [CNT_W-1:0]        out_count;

    // stimulus table, one entry per row
    string             row_name[$];
    logic [N-1:0][31:0] row_words[$];
    logic [N-1:0]      row_valid[$];
    credit_ret_t       row_ret[$];
    int                row_take[$];

    // reference model state
    int                      rob_cnt;
    int                      rs_cnt;
    int                      sq_cnt;
    int                      bs_cnt;
    int                      tail_m;
    int                      exp_take;
    int                      exp_stores;
    int                      exp_branches;
    decoded_packet_t [N-1:0] exp_bundle;
    logic [N-1:0][31:0]      cur_words;
    integer                  seed;

    dispatch_stage dispatch_stage_inst (
        .clock     (clock),
        .rst_n     (rst_n),
        .insts     (insts),
        .credit_ret(credit_ret),
        .take_count(take_count),
        .out_bundle(out_bundle),
        .out_count (out_count)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic abort_run(input string why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] exp,
                               input logic [CNT_W-1:0] act);
        if (act !== exp) begin
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
            abort_run("count mismatch");
        end
    endtask

    task automatic check_packet(input string name, input int slot,
                                input decoded_packet_t exp, input decoded_packet_t act);
        if (act !== exp) begin
            $display("** Error %s slot %0d: expected %h, actual %h", name, slot, exp, act);
            abort_run("packet mismatch");
        end
    endtask

    // returns just after the next falling edge of the clock
    task automatic wait_falling();
        logic prev;
        int   waited;
        prev   = clock;
        waited = 0;
        while (waited < EDGE_WAIT) begin
            #1;
            waited++;
            if (prev === 1'b1 && clock === 1'b0) begin
                return;
            end
            prev = clock;
        end
        abort_run("timeout: the clock stopped producing falling edges");
    endtask

    task automatic wait_reset_clear();
        logic idle;
        for (int c = 0; c < IDLE_WAIT; c++) begin
            idle = (out_count == '0);
            for (int i = 0; i < N; i++) begin
                idle = idle && !out_bundle[i].valid;
            end
            if (rst_n && idle) begin
                return;
            end
            wait_falling();
        end
        abort_run("timeout: outputs did not clear after reset");
    endtask

    task automatic add_row(input string name, input logic [31:0] w0, input logic [31:0] w1,
                           input logic [31:0] w2, input logic [31:0] w3,
                           input logic [N-1:0] v, input int r_rob, input int r_rs,
                           input int r_sq, input int r_bs, input int take);
        credit_ret_t ret;
        ret.rob = CNT_W'(r_rob);
        ret.rs  = CNT_W'(r_rs);
        ret.sq  = CNT_W'(r_sq);
        ret.bs  = CNT_W'(r_bs);
        row_name.push_back(name);
        row_words.push_back({w3, w2, w1, w0});
        row_valid.push_back(v);
        row_ret.push_back(ret);
        row_take.push_back(take);
    endtask

    task automatic build_table();
        add_row("alu_full",      FILL, FILL, FILL, FILL, 4'b1111, 0, 0, 0, 0, 4);
        add_row("rs_drain",      FILL, FILL, FILL, FILL, 4'b1111, 0, 2, 0, 0, 4);
        add_row("rs_limit",      FILL, FILL, FILL, FILL, 4'b1111, 4, 4, 0, 0, 2);
        add_row("partial_valid", FILL, FILL, FILL, FILL, 4'b0111, 0, 3, 0, 0, 3);
        add_row("rob_drain",     FILL, FILL, FILL, FILL, 4'b1111, 0, 4, 0, 0, 4);
        add_row("rob_limit",     FILL, FILL, FILL, FILL, 4'b1111, 4, 4, 0, 0, 3);
        add_row("br_slot0",      BEQ, FILL, FILL, FILL, 4'b1111, 4, 4, 0, 0, 4);
        add_row("bne_alone",     BNE_NEG, FILL, FILL, FILL, 4'b0001, 1, 1, 0, 0, 1);
        add_row("jal_alone",     JAL, FILL, FILL, FILL, 4'b0001, 1, 1, 0, 0, 1);
        add_row("jalr_alone",    JALR, FILL, FILL, FILL, 4'b0001, 1, 1, 0, 0, 1);
        add_row("br_blocked",    BEQ, FILL, FILL, FILL, 4'b0001, 0, 0, 0, 2, 0);
        add_row("br_slot2",      FILL, FILL, BEQ, FILL, 4'b1111, 2, 2, 0, 0, 2);
        add_row("br_resume",     BEQ, FILL, FILL, FILL, 4'b1111, 4, 4, 0, 3, 4);
        add_row("store_tags",    SW_NEG, LW, SW_NEG, SW_NEG, 4'b1111, 4, 4, 0, 0, 4);
        add_row("store_wrap",    SW_NEG, SW_NEG, SW_NEG, LW, 4'b1111, 4, 4, 0, 0, 4);
        add_row("store_limit",   SW_NEG, SW_NEG, SW_NEG, FILL, 4'b1111, 2, 2, 4, 0, 2);
        add_row("store_wrapped", SW_NEG, LW, FILL, FILL, 4'b1111, 4, 4, 4, 0, 4);
        add_row("decode_upper",  LUI, AUIPC, ADD, ADDI, 4'b1111, 4, 4, 0, 0, 4);
        add_row("illegal",       ILL, LW_BAD, FILL, FILL, 4'b1111, 4, 4, 0, 0, 4);
        add_row("decode_signed", BNE_NEG, SW_NEG, LW, FILL, 4'b1111, 4, 4, 0, 1, 4);
        add_row("drain_a",       FILL, FILL, FILL, FILL, 4'b1111, 0, 0, 0, 0, 4);
        add_row("drain_b",       FILL, FILL, FILL, FILL, 4'b1111, 0, 0, 0, 0, 0);
        add_row("drained",       FILL, FILL, FILL, FILL, 4'b1111, 3, 3, 0, 0, 0);
        add_row("resume",        FILL, FILL, FILL, FILL, 4'b1111, 4, 4, 0, 0, 3);
    endtask

    function automatic int open_of(input int cnt);
        return (cnt > N) ? N : cnt;
    endfunction

    function automatic logic [31:0] ref_imm(input logic [31:0] w);
        case (w[6:0])
            OPC_LUI, OPC_AUIPC:          return {w[31:12], 12'b0};
            OPC_JAL:                     return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: return {{20{w[31]}}, w[31:20]};
            OPC_BRANCH:                  return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            OPC_STORE:                   return {{20{w[31]}}, w[31:25], w[11:7]};
            default:                     return 32'b0;
        endcase
    endfunction

    function automatic decoded_packet_t ref_decode(input logic [31:0] w, input logic v,
                                                   input logic [31:0] pc);
        decoded_packet_t d;
        logic [2:0]      f3;
        logic            bad;
        d        = '0;
        f3       = w[14:12];
        bad      = 1'b0;
        d.valid  = v;
        d.pc     = pc;
        d.rd     = w[11:7];
        d.rs1    = w[19:15];
        d.rs2    = w[24:20];
        d.funct3 = f3;
        d.imm    = ref_imm(w);
        d.op_class = CLS_ALU;
        case (w[6:0])
            OPC_LUI, OPC_AUIPC: d.writes_rd = 1'b1;
            OPC_JAL, OPC_JALR: begin
                d.op_class      = CLS_JUMP;
                d.uses_rs1      = (w[6:0] == OPC_JALR);
                d.writes_rd     = 1'b1;
                d.uncond_branch = 1'b1;
            end
            OPC_BRANCH: begin
                d.op_class    = CLS_BRANCH;
                {d.uses_rs1, d.uses_rs2, d.cond_branch} = 3'b111;
                bad           = (f3 == 3'd2) || (f3 == 3'd3);
            end
            OPC_LOAD: begin
                d.op_class = CLS_LOAD;
                {d.uses_rs1, d.writes_rd, d.rd_mem} = 3'b111;
                bad        = (f3 == 3'd3) || (f3 > 3'd5);
            end
            OPC_STORE: begin
                d.op_class = CLS_STORE;
                {d.uses_rs1, d.uses_rs2, d.wr_mem} = 3'b111;
                bad        = (f3 > 3'd2);
            end
            OPC_OP_IMM: {d.uses_rs1, d.writes_rd} = 2'b11;
            OPC_OP:     {d.uses_rs1, d.uses_rs2, d.writes_rd} = 3'b111;
            default:    bad = 1'b1;
        endcase
        if (bad) begin
            d.op_class = CLS_ILLEGAL;
            d.imm      = '0;
            {d.uses_rs1, d.uses_rs2, d.writes_rd, d.cond_branch} = 4'b0;
            {d.uncond_branch, d.rd_mem, d.wr_mem} = 3'b0;
            d.illegal  = 1'b1;
        end
        return d;
    endfunction

    // expected prefix from the credit, branch and store rules
    task automatic ref_select();
        decoded_packet_t p;
        logic            stop;
        logic            is_br;
        int              limit;
        exp_bundle   = '0;
        exp_take     = 0;
        exp_stores   = 0;
        exp_branches = 0;
        stop         = 1'b0;
        limit        = (open_of(rob_cnt) < open_of(rs_cnt)) ? open_of(rob_cnt) : open_of(rs_cnt);
        for (int i = 0; i < N; i++) begin
            p     = ref_decode(cur_words[i], insts[i].valid, insts[i].pc);
            is_br = p.cond_branch || p.uncond_branch;
            if (stop || !p.valid || i >= limit) begin
                stop = 1'b1;
            end else if (is_br && (i != 0 || open_of(bs_cnt) == 0)) begin
                stop = 1'b1;
            end else if (p.wr_mem && exp_stores >= open_of(sq_cnt)) begin
                stop = 1'b1;
            end else begin
                if (p.rd_mem || p.wr_mem) begin
                    p.sq_tail = SQ_IDX_W'((tail_m + exp_stores) % SQ_SZ);
                end
                exp_bundle[i] = p;
                exp_stores   += int'(p.wr_mem);
                exp_branches += int'(is_br);
                exp_take++;
            end
        end
    endtask

    task automatic apply_row(input int r);
        logic [31:0] w;
        logic [31:0] rnd;
        for (int i = 0; i < N; i++) begin
            w = row_words[r][i];
            if (w == FILL) begin
                rnd = $random(seed);
                w   = {rnd[31:15], 3'b000, rnd[11:7], OPC_OP_IMM};
            end
            cur_words[i]    = w;
            insts[i].valid  = row_valid[r][i];
            insts[i].pc     = 32'(r * 16 + i * 4);
            insts[i].inst   = w;
        end
        credit_ret = row_ret[r];
    endtask

    task automatic update_model(input credit_ret_t ret);
        rob_cnt = rob_cnt - exp_take + int'(ret.rob);
        rs_cnt  = rs_cnt - exp_take + int'(ret.rs);
        sq_cnt  = sq_cnt - exp_stores + int'(ret.sq);
        bs_cnt  = bs_cnt - exp_branches + int'(ret.bs);
        tail_m  = (tail_m + exp_stores) % SQ_SZ;
    endtask

    initial begin
        seed       = 32'hc412_4a78;
        rst_n      = 1'b0;
        insts      = '0;
        credit_ret = '0;
        cur_words  = '0;
        rob_cnt    = ROB_SZ;
        rs_cnt     = RS_SZ;
        sq_cnt     = SQ_SZ;
        bs_cnt     = BS_SZ;
        tail_m     = 0;
        build_table();
        #0.5;
        wait_falling();
        wait_falling();
        rst_n = 1'b1;
        wait_reset_clear();
        for (int r = 0; r < row_name.size(); r++) begin
            apply_row(r);
            #2;
            ref_select();
            if (exp_take != row_take[r]) begin
                $display("table and reference model disagree on take count in %s", row_name[r]);
                abort_run("stimulus table is inconsistent");
            end
            check_count({row_name[r], " take_count"}, CNT_W'(row_take[r]), take_count);
            wait_falling();
            check_count({row_name[r], " out_count"}, CNT_W'(exp_take), out_count);
            for (int i = 0; i < N; i++) begin
                check_packet(row_name[r], i, exp_bundle[i], out_bundle[i]);
            end
            update_model(row_ret[r]);
        end
        insts      = '0;
        credit_ret = '0;
        $display("TEST PASSED");
        $finish;
    end

endmodule
